/* pipe_pkg.sv */
package pipe_pkg;

  localparam int DATA_W = 32;
  localparam int REG_W = 5;

  // ALU class first, then the two multiply opcodes
  typedef enum logic [2:0] {
    OP_ADD,
    OP_SUB,
    OP_AND,
    OP_OR,
    OP_XOR,
    OP_SLL,
    OP_MUL,
    OP_MULHU
  } op_t;

  typedef struct packed {
    op_t               op;
    logic [REG_W-1:0]  rd;
    logic [DATA_W-1:0] a;
    logic [DATA_W-1:0] b;
  } inst_t;

  typedef struct packed {
    logic [REG_W-1:0]  rd;
    logic [DATA_W-1:0] value;
  } retire_t;

  function automatic logic is_mul(op_t op);
    return (op == OP_MUL) || (op == OP_MULHU);
  endfunction

endpackage

/* alu_unit.sv */
module alu_unit #(
  parameter int ROB_DEPTH = 8,
  localparam int TAG_W = $clog2(ROB_DEPTH)
) (
  input  logic                        clock,
  input  logic                        rst,
  input  logic                        issue_en,
  input  pipe_pkg::inst_t             issue_inst,
  input  logic [TAG_W-1:0]            issue_tag,
  output logic                        wb_valid,
  output logic [TAG_W-1:0]            wb_tag,
  output logic [pipe_pkg::DATA_W-1:0] wb_data
);
  import pipe_pkg::*;

  logic [DATA_W-1:0] result;

  always_comb begin
    case (issue_inst.op)
      OP_ADD:  result = issue_inst.a + issue_inst.b;
      OP_SUB:  result = issue_inst.a - issue_inst.b;
      OP_AND:  result = issue_inst.a & issue_inst.b;
      OP_OR:   result = issue_inst.a | issue_inst.b;
      OP_XOR:  result = issue_inst.a ^ issue_inst.b;
      // Shift amount from the low five bits only
      OP_SLL:  result = issue_inst.a << issue_inst.b[4:0];
      default: result = '0;
    endcase
  end

  always_ff @(posedge clock) begin
    if (rst) begin
      wb_valid <= 1'b0;
    end else begin
      wb_valid <= issue_en && !is_mul(issue_inst.op);
    end
    wb_tag  <= issue_tag;
    wb_data <= result;
  end

  // No stale result may reach the ROB right after reset
  a_no_wb_after_rst: assert property (@(posedge clock) rst |=> !wb_valid)
    else $error("alu_unit: wb_valid high in the cycle after reset");

endmodule

/* mul_unit.sv */
module mul_unit #(
  parameter int ROB_DEPTH = 8,
  parameter int MUL_STAGES = 3,
  localparam int TAG_W = $clog2(ROB_DEPTH)
) (
  input  logic                        clock,
  input  logic                        rst,
  input  logic                        issue_en,
  input  pipe_pkg::inst_t             issue_inst,
  input  logic [TAG_W-1:0]            issue_tag,
  output logic                        wb_valid,
  output logic [TAG_W-1:0]            wb_tag,
  output logic [pipe_pkg::DATA_W-1:0] wb_data
);
  import pipe_pkg::*;

  typedef struct packed {
    logic [TAG_W-1:0]  tag;
    logic [DATA_W-1:0] data;
  } stage_t;

  logic [2*DATA_W-1:0]   product;
  logic [DATA_W-1:0]     half;
  logic                  take;
  logic [MUL_STAGES-1:0] vld_q;
  stage_t                stage_q [MUL_STAGES];

  assign take = issue_en && is_mul(issue_inst.op);

  // Full unsigned product, then pick the half the opcode asks for
  assign product = (2*DATA_W)'(issue_inst.a) * (2*DATA_W)'(issue_inst.b);
  assign half = (issue_inst.op == OP_MULHU) ? product[2*DATA_W-1:DATA_W]
                                            : product[DATA_W-1:0];

  always_ff @(posedge clock) begin
    if (rst) begin
      vld_q <= '0;
    end else begin
      vld_q <= (vld_q << 1) | MUL_STAGES'(take);
    end
  end

  always_ff @(posedge clock) begin
    stage_q[0].tag  <= issue_tag;
    stage_q[0].data <= half;
    for (int i = 1; i < MUL_STAGES; i++) begin
      stage_q[i] <= stage_q[i-1];
    end
  end

  // Oldest stage feeds the write port
  assign wb_valid = vld_q[MUL_STAGES-1];
  assign wb_tag   = stage_q[MUL_STAGES-1].tag;
  assign wb_data  = stage_q[MUL_STAGES-1].data;

  a_min_stages: assert property (@(posedge clock) MUL_STAGES >= 1)
    else $error("mul_unit: MUL_STAGES must be at least 1");

endmodule

/* rob.sv */
module rob #(
  parameter int ROB_DEPTH = 8,
  localparam int TAG_W = $clog2(ROB_DEPTH)
) (
  input  logic                        clock,
  input  logic                        rst,
  input  logic                        in_valid,
  input  pipe_pkg::inst_t             in_inst,
  input  logic                        alu_wb_valid,
  input  logic [TAG_W-1:0]            alu_wb_tag,
  input  logic [pipe_pkg::DATA_W-1:0] alu_wb_data,
  input  logic                        mul_wb_valid,
  input  logic [TAG_W-1:0]            mul_wb_tag,
  input  logic [pipe_pkg::DATA_W-1:0] mul_wb_data,
  input  logic                        retire_hold,
  output logic                        full,
  output logic                        issue_en,
  output logic [TAG_W-1:0]            issue_tag,
  output logic                        retire_valid,
  output pipe_pkg::retire_t           retire
);
  import pipe_pkg::*;

  logic [ROB_DEPTH-1:0] busy_q;
  logic [ROB_DEPTH-1:0] done_q;
  retire_t              entry_q [ROB_DEPTH];
  logic [TAG_W-1:0]     head_q;
  logic [TAG_W-1:0]     tail_q;
  logic [TAG_W:0]       count_q;
  logic                 retire_go;

  // Wrap explicitly so a depth that is not a power of two still works
  function automatic logic [TAG_W-1:0] next_ptr(logic [TAG_W-1:0] ptr);
    return (ptr == TAG_W'(ROB_DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign full      = (count_q == (TAG_W + 1)'(ROB_DEPTH));
  assign issue_en  = in_valid && !full;
  assign issue_tag = tail_q;

  // Head leaves once its result is in and write-back is not stalled
  assign retire_go = done_q[head_q] && !retire_hold;

  always_ff @(posedge clock) begin
    if (rst) begin
      busy_q       <= '0;
      done_q       <= '0;
      head_q       <= '0;
      tail_q       <= '0;
      count_q      <= '0;
      retire_valid <= 1'b0;
    end else begin
      retire_valid <= retire_go;
      count_q <= count_q + (TAG_W + 1)'(issue_en) - (TAG_W + 1)'(retire_go);
      if (retire_go) begin
        busy_q[head_q] <= 1'b0;
        done_q[head_q] <= 1'b0;
        head_q         <= next_ptr(head_q);
      end
      if (issue_en) begin
        busy_q[tail_q] <= 1'b1;
        done_q[tail_q] <= 1'b0;
        tail_q         <= next_ptr(tail_q);
      end
      if (alu_wb_valid) begin
        done_q[alu_wb_tag] <= 1'b1;
      end
      if (mul_wb_valid) begin
        done_q[mul_wb_tag] <= 1'b1;
      end
    end
  end

  // Entry payload
  always_ff @(posedge clock) begin
    if (issue_en) begin
      entry_q[tail_q].rd <= in_inst.rd;
    end
    if (alu_wb_valid) begin
      entry_q[alu_wb_tag].value <= alu_wb_data;
    end
    if (mul_wb_valid) begin
      entry_q[mul_wb_tag].value <= mul_wb_data;
    end
    if (retire_go) begin
      retire <= entry_q[head_q];
    end
  end

  a_alu_wr_live: assert property (@(posedge clock) disable iff (rst)
    alu_wb_valid |-> busy_q[alu_wb_tag] && !done_q[alu_wb_tag])
    else $error("rob: ALU result for a free or finished entry");

  a_mul_wr_live: assert property (@(posedge clock) disable iff (rst)
    mul_wb_valid |-> busy_q[mul_wb_tag] && !done_q[mul_wb_tag])
    else $error("rob: multiplier result for a free or finished entry");

  a_wr_no_clash: assert property (@(posedge clock) disable iff (rst)
    alu_wb_valid && mul_wb_valid |-> alu_wb_tag != mul_wb_tag)
    else $error("rob: both units wrote the same tag");

  a_hold_blocks: assert property (@(posedge clock) disable iff (rst)
    retire_hold |=> !retire_valid)
    else $error("rob: retired while write-back was stalled");

endmodule

/* pipeline.sv */
module pipeline #(
  parameter int ROB_DEPTH = 8,
  parameter int MUL_STAGES = 3,
  localparam int TAG_W = $clog2(ROB_DEPTH)
) (
  input  logic              clock,
  input  logic              rst,
  input  logic              in_valid,
  input  pipe_pkg::inst_t   in_inst,
  output logic              full,
  input  logic              retire_hold,
  output logic              retire_valid,
  output pipe_pkg::retire_t retire
);
  import pipe_pkg::*;

  logic              issue_en;
  logic [TAG_W-1:0]  issue_tag;

  logic              alu_wb_valid;
  logic [TAG_W-1:0]  alu_wb_tag;
  logic [DATA_W-1:0] alu_wb_data;

  logic              mul_wb_valid;
  logic [TAG_W-1:0]  mul_wb_tag;
  logic [DATA_W-1:0] mul_wb_data;

  rob #(
    .ROB_DEPTH (ROB_DEPTH)
  ) i_rob (
    .clock        (clock),
    .rst          (rst),
    .in_valid     (in_valid),
    .in_inst      (in_inst),
    .alu_wb_valid (alu_wb_valid),
    .alu_wb_tag   (alu_wb_tag),
    .alu_wb_data  (alu_wb_data),
    .mul_wb_valid (mul_wb_valid),
    .mul_wb_tag   (mul_wb_tag),
    .mul_wb_data  (mul_wb_data),
    .retire_hold  (retire_hold),
    .full         (full),
    .issue_en     (issue_en),
    .issue_tag    (issue_tag),
    .retire_valid (retire_valid),
    .retire       (retire)
  );

  // Both units see every issue and pick their own class
  alu_unit #(
    .ROB_DEPTH (ROB_DEPTH)
  ) i_alu (
    .clock      (clock),
    .rst        (rst),
    .issue_en   (issue_en),
    .issue_inst (in_inst),
    .issue_tag  (issue_tag),
    .wb_valid   (alu_wb_valid),
    .wb_tag     (alu_wb_tag),
    .wb_data    (alu_wb_data)
  );

  mul_unit #(
    .ROB_DEPTH  (ROB_DEPTH),
    .MUL_STAGES (MUL_STAGES)
  ) i_mul (
    .clock      (clock),
    .rst        (rst),
    .issue_en   (issue_en),
    .issue_inst (in_inst),
    .issue_tag  (issue_tag),
    .wb_valid   (mul_wb_valid),
    .wb_tag     (mul_wb_tag),
    .wb_data    (mul_wb_data)
  );

endmodule

/* tb_pipeline.sv */
module tb_pipeline;
  import pipe_pkg::*;

  localparam int ROB_DEPTH = 8;
  localparam int MUL_STAGES = 3;
  localparam int CLK_PERIOD = 40;
  localparam int N_ALU = 40;
  localparam int N_MUL = 30;
  localparam int N_MIX = 60;
  // Back-pressure fills the ROB and then offers one more
  localparam int N_TOTAL = N_ALU + N_MUL + N_MIX + ROB_DEPTH + 1;
  localparam int WATCHDOG_CYCLES = N_TOTAL * (MUL_STAGES + ROB_DEPTH + 4) + 200;
  localparam int SEED = 32'h286b_922d;

  logic    clock;
  logic    rst;
  logic    in_valid;
  inst_t   in_inst;
  logic    full;
  logic    retire_hold;
  logic    retire_valid;
  retire_t retire;

  retire_t exp_q[$];
  retire_t expected;
  string   cur_test = "init";
  int      chk_errors = 0;
  int      mon_errors = 0;
  int      tests_run = 0;
  int      tests_bad = 0;
  int      errs_at_start = 0;
  logic    hold_prev;

  pipeline #(
    .ROB_DEPTH  (ROB_DEPTH),
    .MUL_STAGES (MUL_STAGES)
  ) i_dut (
    .clock        (clock),
    .rst          (rst),
    .in_valid     (in_valid),
    .in_inst      (in_inst),
    .full         (full),
    .retire_hold  (retire_hold),
    .retire_valid (retire_valid),
    .retire       (retire)
  );

  initial clock = 1'b0;
  always #(CLK_PERIOD / 2) clock = ~clock;

  // Expected retire entry, straight from the opcode definitions
  function automatic retire_t ref_exec(input inst_t inst);
    retire_t     r;
    logic [63:0] prod;
    prod = {32'b0, inst.a} * {32'b0, inst.b};
    r.rd = inst.rd;
    case (inst.op)
      OP_ADD:   r.value = inst.a + inst.b;
      OP_SUB:   r.value = inst.a - inst.b;
      OP_AND:   r.value = inst.a & inst.b;
      OP_OR:    r.value = inst.a | inst.b;
      OP_XOR:   r.value = inst.a ^ inst.b;
      OP_SLL:   r.value = inst.a << inst.b[4:0];
      OP_MUL:   r.value = prod[31:0];
      OP_MULHU: r.value = prod[63:32];
      default:  r.value = '0;
    endcase
    return r;
  endfunction

  // Corner operands now and then
  function automatic logic [DATA_W-1:0] rand_operand();
    logic [DATA_W-1:0] v;
    case ($urandom_range(7, 0))
      0:       v = '0;
      1:       v = '1;
      default: v = $urandom();
    endcase
    return v;
  endfunction

  function automatic inst_t rand_inst(input int op_lo, input int op_hi);
    inst_t inst;
    inst.op = op_t'(3'($urandom_range(op_hi, op_lo)));
    inst.rd = REG_W'($urandom());
    inst.a  = rand_operand();
    inst.b  = rand_operand();
    return inst;
  endfunction

  // Scoreboard, sampled at the falling edge where outputs are settled
  always @(negedge clock) begin
    if (rst) begin
      hold_prev <= 1'b0;
    end else begin
      if (retire_valid) begin
        assert (exp_q.size() != 0) else begin
          $display("%s: retire_valid with no instruction outstanding", cur_test);
          mon_errors++;
        end
        if (exp_q.size() != 0) begin
          expected = exp_q.pop_front();
          assert (retire == expected) else begin
            $display("FAILED %s expected rd=%0d value=%h actual rd=%0d value=%h",
                     cur_test, expected.rd, expected.value, retire.rd, retire.value);
            mon_errors++;
          end
        end
      end
      assert (!(hold_prev && retire_valid)) else begin
        $display("%s: an instruction retired while retire_hold was high", cur_test);
        mon_errors++;
      end
      hold_prev <= retire_hold;
    end
  end

  task automatic start_test(input string name);
    cur_test = name;
    errs_at_start = chk_errors + mon_errors;
  endtask

  // Waits for every expected retire, then reports the test
  task automatic end_test();
    int errs;
    while (exp_q.size() != 0) begin
      @(posedge clock);
      #2;
    end
    errs = chk_errors + mon_errors - errs_at_start;
    tests_run++;
    if (errs == 0) begin
      $display("test %s: ok", cur_test);
    end else begin
      tests_bad++;
      $display("test %s: %0d errors", cur_test, errs);
    end
  endtask

  // Entered 2 units after an edge with in_inst already driven
  task automatic complete_offer(input inst_t inst);
    #1;
    while (full) begin
      @(posedge clock);
      #3;
    end
    exp_q.push_back(ref_exec(inst));
    @(posedge clock);
    #2;
    in_valid = 1'b0;
  endtask

  task automatic offer(input inst_t inst);
    in_valid = 1'b1;
    in_inst  = inst;
    complete_offer(inst);
  endtask

  task automatic check_reset();
    start_test("reset_state");
    for (int i = 0; i < 8; i++) begin
      @(posedge clock);
      #1;
      assert (retire_valid === 1'b0) else begin
        $display("FAILED reset_state expected retire_valid=0 actual %b", retire_valid);
        chk_errors++;
      end
      assert (full === 1'b0) else begin
        $display("FAILED reset_state expected full=0 actual %b", full);
        chk_errors++;
      end
      #1;
      if (i == 4) begin
        rst = 1'b0;
      end
    end
    end_test();
  endtask

  task automatic alu_ops();
    start_test("alu_ops");
    repeat (N_ALU) offer(rand_inst(0, 5));
    end_test();
  endtask

  task automatic mul_ops();
    start_test("mul_ops");
    repeat (N_MUL) offer(rand_inst(6, 7));
    end_test();
  endtask

  task automatic mixed_order();
    start_test("mixed_order");
    for (int i = 0; i < N_MIX; i++) begin
      // A multiply, two ALU ops right behind it, then anything
      case (i % 5)
        0:       offer(rand_inst(6, 7));
        1, 2:    offer(rand_inst(0, 5));
        default: offer(rand_inst(0, 7));
      endcase
      if ($urandom_range(7, 0) == 0) begin
        @(posedge clock);
        #2;
      end
    end
    end_test();
  endtask

  task automatic back_pressure();
    inst_t inst;
    int    n;
    start_test("back_pressure");
    n = 0;
    retire_hold = 1'b1;
    inst = rand_inst(0, 7);
    in_valid = 1'b1;
    in_inst = inst;
    #1;
    while (!full && n <= ROB_DEPTH) begin
      exp_q.push_back(ref_exec(inst));
      n++;
      @(posedge clock);
      #2;
      inst = rand_inst(0, 7);
      in_inst = inst;
      #1;
    end
    assert (n == ROB_DEPTH) else begin
      $display("FAILED back_pressure expected %0d accepted actual %0d", ROB_DEPTH, n);
      chk_errors++;
    end
    // Pending instruction stays offered while the ROB is full
    repeat (4) begin
      @(posedge clock);
      #3;
      assert (full) else begin
        $display("back_pressure: full dropped while retire_hold was high");
        chk_errors++;
      end
    end
    @(posedge clock);
    #2;
    retire_hold = 1'b0;
    complete_offer(inst);
    end_test();
  endtask

  initial begin
    void'($urandom(SEED));
    rst = 1'b1;
    in_valid = 1'b0;
    in_inst = '0;
    retire_hold = 1'b0;
    check_reset();
    alu_ops();
    mul_ops();
    mixed_order();
    back_pressure();
    $display("Summary: %0d tests, %0d with errors, %0d check errors, %0d scoreboard errors",
             tests_run, tests_bad, chk_errors, mon_errors);
    if (chk_errors + mon_errors == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("Watchdog: run did not finish within %0d clock cycles", WATCHDOG_CYCLES);
    $display("Some tests failed");
    $finish;
  end

endmodule

/* tb.f */
pipe_pkg.sv
alu_unit.sv
mul_unit.sv
rob.sv
pipeline.sv
tb_pipeline.sv

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" && \
verilator --binary --assert --top-module tb_pipeline -f tb.f -o tb_pipeline && \
./obj_dir/tb_pipeline | tee /dev/stderr | grep -q "All tests passed" || \
{ echo "simulation did not pass" >&2; exit 1; }
